// ==== logic/aes_mix_pkg.sv ====
// AES round mixing package
package aes_mix_pkg;

  // GF(2^8) element
  typedef logic [7:0] aes_byte_t;
  // One column, byte r at bits 8r+7:8r
  typedef logic [31:0] aes_col_t;
  // Full state, column c at bits 32c+31:32c
  typedef logic [127:0] aes_state_t;

  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  // Byte offsets of the 32-bit registers
  localparam logic [7:0] CTRL_OFFSET   = 8'h00;
  localparam logic [7:0] STATUS_OFFSET = 8'h04;
  localparam logic [7:0] STATE_BASE    = 8'h10;
  localparam logic [7:0] KEY_BASE      = 8'h20;
  localparam logic [7:0] RESULT_BASE   = 8'h30;

  // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
  function automatic aes_byte_t aes_mul2(aes_byte_t in);
    aes_byte_t out;
    out = {in[6:0], 1'b0};
    // Reduce when the top bit shifts out
    if (in[7]) begin
      out = out ^ 8'h1b;
    end
    return out;
  endfunction

  // Multiply by x^2, two doublings in a row
  function automatic aes_byte_t aes_mul4(aes_byte_t in);
    return aes_mul2(aes_mul2(in));
  endfunction

endpackage

// ==== logic/aes_cfg_if.sv ====
// Datapath configuration interface
`timescale 1ns/1ps
interface aes_cfg_if;
  import aes_mix_pkg::*;

  // Register block outputs
  aes_state_t state;
  aes_state_t key;
  ciph_op_e   op;
  logic       key_inv;
  logic       start;

  // Datapath results
  aes_state_t mixed;
  aes_state_t prepped_key;
  aes_state_t result;
  logic       done;

  modport regs (output state, key, op, key_inv, start, input result, done);
  modport mix (input state, op, output mixed);
  modport key_prep (input key, op, key_inv, output prepped_key);
  modport combine (input start, mixed, prepped_key, output result, done);

endinterface

// ==== logic/aes_mix_single_column.sv ====
// Single column MixColumns and InvMixColumns
`timescale 1ns/1ps
module aes_mix_single_column (
  input  aes_mix_pkg::ciph_op_e op_i,
  input  aes_mix_pkg::aes_col_t data_i,
  output aes_mix_pkg::aes_col_t data_o
);
  import aes_mix_pkg::*;

  aes_byte_t [3:0] a;
  aes_byte_t [3:0] x;
  aes_byte_t [3:0] x_dbl;
  aes_byte_t [1:0] y;
  aes_byte_t       y2;
  aes_byte_t [1:0] z;
  aes_byte_t [1:0] z_sel;
  aes_byte_t [3:0] o;

  assign a = data_i;

  // Neighbour pair sums
  assign x[0] = a[0] ^ a[3];
  assign x[1] = a[3] ^ a[2];
  assign x[2] = a[2] ^ a[1];
  assign x[3] = a[1] ^ a[0];

  for (genvar i = 0; i < 4; i++) begin : gen_x_dbl
    assign x_dbl[i] = aes_mul2(x[i]);
  end

  // Cross pairs times 4
  assign y[0] = aes_mul4(a[3] ^ a[1]);
  assign y[1] = aes_mul4(a[2] ^ a[0]);

  // Sum of all four bytes times 8
  assign y2 = aes_mul2(y[0] ^ y[1]);

  // Inverse correction, 12a0^8a1^12a2^8a3 style terms
  assign z[0] = y2 ^ y[0];
  assign z[1] = y2 ^ y[1];

  // No correction in forward direction
  assign z_sel[0] = (op_i == CIPH_INV) ? z[0] : 8'h00;
  assign z_sel[1] = (op_i == CIPH_INV) ? z[1] : 8'h00;

  // Forward terms plus correction
  assign o[0] = a[1] ^ x_dbl[3] ^ x[1] ^ z_sel[1];
  assign o[1] = a[0] ^ x_dbl[2] ^ x[1] ^ z_sel[0];
  assign o[2] = a[3] ^ x_dbl[1] ^ x[3] ^ z_sel[1];
  assign o[3] = a[2] ^ x_dbl[0] ^ x[3] ^ z_sel[0];

  assign data_o = o;

endmodule

// ==== logic/aes_state_mix.sv ====
// State row shift and column mix
`timescale 1ns/1ps
module aes_state_mix (
  aes_cfg_if.mix cfg
);
  import aes_mix_pkg::*;

  aes_state_t mix_in;
  aes_state_t mix_out;
  aes_state_t mixed;

  // Forward row r rotated left by r columns before mixing
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        if (cfg.op == CIPH_FWD) begin
          mix_in[32*c+8*r +: 8] = cfg.state[32*((c+r)%4)+8*r +: 8];
        end else begin
          mix_in[32*c+8*r +: 8] = cfg.state[32*c+8*r +: 8];
        end
      end
    end
  end

  for (genvar c = 0; c < 4; c++) begin : gen_col
    aes_mix_single_column col_mix_inst (
      .op_i   (cfg.op),
      .data_i (mix_in[32*c +: 32]),
      .data_o (mix_out[32*c +: 32])
    );
  end

  // Inverse row r rotated right by r columns after mixing
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        if (cfg.op == CIPH_FWD) begin
          mixed[32*c+8*r +: 8] = mix_out[32*c+8*r +: 8];
        end else begin
          mixed[32*c+8*r +: 8] = mix_out[32*((c+4-r)%4)+8*r +: 8];
        end
      end
    end
  end

  assign cfg.mixed = mixed;

  // Each matrix row sums to one so a repeated byte passes through
  always_comb begin
    if (cfg.state == {16{cfg.state[7:0]}}) begin
      assert final (cfg.mixed == cfg.state);
    end
  end

endmodule

// ==== logic/aes_round_key_prep.sv ====
// Round key preparation
`timescale 1ns/1ps
module aes_round_key_prep (
  aes_cfg_if.key_prep cfg
);
  import aes_mix_pkg::*;

  aes_state_t inv_key;
  logic       use_inv;

  // Equivalent inverse cipher needs InvMixColumns on the key
  for (genvar c = 0; c < 4; c++) begin : gen_col
    aes_mix_single_column key_mix_inst (
      .op_i   (CIPH_INV),
      .data_i (cfg.key[32*c +: 32]),
      .data_o (inv_key[32*c +: 32])
    );
  end

  assign use_inv = (cfg.op == CIPH_INV) && cfg.key_inv;

  // Raw key unless both flags set
  assign cfg.prepped_key = use_inv ? inv_key : cfg.key;

  // InvMixColumns leaves a repeated byte unchanged
  always_comb begin
    if (cfg.key == {16{cfg.key[7:0]}}) begin
      assert final (cfg.prepped_key == cfg.key);
    end
  end

endmodule

// ==== logic/aes_round_combine.sv ====
// Round key addition register
`timescale 1ns/1ps
module aes_round_combine (
  input logic        clk_i,
  input logic        rst_n_i,
  aes_cfg_if.combine cfg
);
  import aes_mix_pkg::*;

  aes_state_t result_q;
  logic       done_q;

  // Capture one cycle after the start write
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_q <= '0;
      done_q   <= 1'b0;
    end else if (cfg.start) begin
      result_q <= cfg.mixed ^ cfg.prepped_key;
      // Sticky until reset
      done_q   <= 1'b1;
    end
  end

  assign cfg.result = result_q;
  assign cfg.done   = done_q;

  // Done only clears through reset
  assert property (@(posedge clk_i) $past(rst_n_i) && $past(done_q) |-> done_q);

endmodule

// ==== logic/aes_apb_regs.sv ====
// APB register block
`timescale 1ns/1ps
module aes_apb_regs #(
  parameter int ADDR_W = 8
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [ADDR_W-1:0] paddr_i,
  input  logic [31:0]       pwdata_i,
  output logic [31:0]       prdata_o,
  output logic              pready_o,
  output logic              pslverr_o,
  aes_cfg_if.regs           cfg
);
  import aes_mix_pkg::*;

  logic              access;
  logic              wr_en;
  logic [ADDR_W-1:0] page_addr;
  logic [1:0]        word_sel;
  logic              aligned;
  logic              is_ctrl;
  logic              is_status;
  logic              is_state;
  logic              is_key;
  logic              is_result;
  logic              mapped;
  logic              bad_write;
  logic [31:0]       rdata;

  aes_state_t state_q;
  aes_state_t key_q;
  ciph_op_e   op_q;
  logic       key_inv_q;
  logic       start_q;

  // Zero wait states so only the access phase counts
  assign access = psel_i && penable_i;
  assign wr_en  = access && pwrite_i;

  // Word decode inside each 16-byte block
  assign word_sel  = paddr_i[3:2];
  assign aligned   = (paddr_i[1:0] == 2'b00);
  assign page_addr = {paddr_i[ADDR_W-1:4], 4'h0};

  assign is_ctrl   = (paddr_i == ADDR_W'(CTRL_OFFSET));
  assign is_status = (paddr_i == ADDR_W'(STATUS_OFFSET));
  assign is_state  = aligned && (page_addr == ADDR_W'(STATE_BASE));
  assign is_key    = aligned && (page_addr == ADDR_W'(KEY_BASE));
  assign is_result = aligned && (page_addr == ADDR_W'(RESULT_BASE));
  assign mapped    = is_ctrl || is_status || is_state || is_key || is_result;

  // Status and result are read only
  assign bad_write = pwrite_i && (is_status || is_result);

  // Control bits and start pulse
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      op_q      <= CIPH_FWD;
      key_inv_q <= 1'b0;
      start_q   <= 1'b0;
    end else begin
      start_q <= 1'b0;
      if (wr_en && is_ctrl) begin
        start_q   <= pwdata_i[0];
        op_q      <= pwdata_i[1] ? CIPH_INV : CIPH_FWD;
        key_inv_q <= pwdata_i[2];
      end
    end
  end

  // State and key words
  always_ff @(posedge clk_i) begin
    if (wr_en && is_state) begin
      state_q[32*word_sel +: 32] <= pwdata_i;
    end
    if (wr_en && is_key) begin
      key_q[32*word_sel +: 32] <= pwdata_i;
    end
  end

  // Read mux with the start bit reading as zero
  always_comb begin
    rdata = 32'h0;
    if (is_ctrl) begin
      rdata = {29'h0, key_inv_q, op_q, 1'b0};
    end else if (is_status) begin
      rdata = {31'h0, cfg.done};
    end else if (is_state) begin
      rdata = state_q[32*word_sel +: 32];
    end else if (is_key) begin
      rdata = key_q[32*word_sel +: 32];
    end else if (is_result) begin
      rdata = cfg.result[32*word_sel +: 32];
    end
  end

  assign prdata_o  = (access && !pwrite_i) ? rdata : 32'h0;
  assign pready_o  = 1'b1;
  assign pslverr_o = access && (!mapped || bad_write);

  assign cfg.state   = state_q;
  assign cfg.key     = key_q;
  assign cfg.op      = op_q;
  assign cfg.key_inv = key_inv_q;
  assign cfg.start   = start_q;

  // APB spacing keeps start to a single cycle
  assert property (@(posedge clk_i) disable iff (!rst_n_i) start_q |=> !start_q);
  // A rejected write touches no operand and starts nothing
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pslverr_o && pwrite_i |=> $stable(state_q) && $stable(key_q) && !start_q);

endmodule

// ==== logic/aes_mix_apb.sv ====
// AES round mixing peripheral
`timescale 1ns/1ps
module aes_mix_apb #(
  parameter int ADDR_W = 8
) (
  input  logic              pclk_i,
  input  logic              rst_n_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [ADDR_W-1:0] paddr_i,
  input  logic [31:0]       pwdata_i,
  output logic [31:0]       prdata_o,
  output logic              pready_o,
  output logic              pslverr_o
);

  // Shared config and result bus
  aes_cfg_if cfg_if ();

  // APB slave and start pulse
  aes_apb_regs #(
    .ADDR_W (ADDR_W)
  ) aes_apb_regs_inst (
    .clk_i     (pclk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .cfg       (cfg_if.regs)
  );

  // Combinational state path
  aes_state_mix aes_state_mix_inst (
    .cfg (cfg_if.mix)
  );

  // Combinational key path
  aes_round_key_prep aes_round_key_prep_inst (
    .cfg (cfg_if.key_prep)
  );

  // Registered sum and done flag
  aes_round_combine aes_round_combine_inst (
    .clk_i   (pclk_i),
    .rst_n_i (rst_n_i),
    .cfg     (cfg_if.combine)
  );

endmodule

// ==== verif/aes_mix_apb_tb.sv ====
// AES round mixing testbench
`timescale 1ns/1ps
module aes_mix_apb_tb;
  import aes_mix_pkg::*;

  localparam int ADDR_W  = 8;
  localparam int TIMEOUT = 16;
  // Holes in the map plus one unaligned address
  localparam logic [7:0] UNMAPPED [5] = '{8'h08, 8'h0c, 8'h11, 8'h40, 8'hfc};

  logic              pclk_i;
  logic              rst_n_i;
  logic              psel_i;
  logic              penable_i;
  logic              pwrite_i;
  logic [ADDR_W-1:0] paddr_i;
  logic [31:0]       pwdata_i;
  logic [31:0]       prdata_o;
  logic              pready_o;
  logic              pslverr_o;

  logic [31:0] lfsr_q;
  int          n_checks;
  int          n_errors;
  int          test_errors;

  aes_mix_apb #(
    .ADDR_W (ADDR_W)
  ) aes_mix_apb_inst (
    .pclk_i    (pclk_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o)
  );

  // 4 ns period
  always #2 pclk_i = ~pclk_i;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per random bit
  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      w = {w[30:0], lfsr_q[0]};
    end
    return w;
  endfunction

  function automatic aes_state_t rand_state();
    aes_state_t s;
    for (int w = 0; w < 4; w++) begin
      s[32*w +: 32] = rand_word();
    end
    return s;
  endfunction

  function automatic aes_byte_t xtime(input aes_byte_t b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  // Textbook constant multiply from xtime chains
  function automatic aes_byte_t gf_mul(input aes_byte_t b, input int k);
    aes_byte_t b2;
    aes_byte_t b4;
    aes_byte_t b8;
    aes_byte_t p;
    b2 = xtime(b);
    b4 = xtime(b2);
    b8 = xtime(b4);
    case (k)
      2:       p = b2;
      3:       p = b2 ^ b;
      9:       p = b8 ^ b;
      11:      p = b8 ^ b2 ^ b;
      13:      p = b8 ^ b4 ^ b;
      14:      p = b8 ^ b4 ^ b2;
      default: p = b;
    endcase
    return p;
  endfunction

  // Circulant matrix rows 2 3 1 1 or 14 11 13 9
  function automatic aes_state_t ref_mix(input aes_state_t s, input logic inv);
    aes_state_t o;
    int m [4];
    m[0] = inv ? 14 : 2;
    m[1] = inv ? 11 : 3;
    m[2] = inv ? 13 : 1;
    m[3] = inv ? 9 : 1;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        o[32*c+8*r +: 8] = gf_mul(s[32*c+8*r +: 8], m[0])
                         ^ gf_mul(s[32*c+8*((r+1)%4) +: 8], m[1])
                         ^ gf_mul(s[32*c+8*((r+2)%4) +: 8], m[2])
                         ^ gf_mul(s[32*c+8*((r+3)%4) +: 8], m[3]);
      end
    end
    return o;
  endfunction

  // Row r moves left by r or right for the inverse
  function automatic aes_state_t ref_shift(input aes_state_t s, input logic inv);
    aes_state_t o;
    int src;
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        src = inv ? (c + 4 - r) % 4 : (c + r) % 4;
        o[32*c+8*r +: 8] = s[32*src+8*r +: 8];
      end
    end
    return o;
  endfunction

  function automatic aes_state_t ref_round(input aes_state_t s, input aes_state_t k,
                                           input ciph_op_e op, input logic key_inv);
    if (op == CIPH_FWD) begin
      return ref_mix(ref_shift(s, 1'b0), 1'b0) ^ k;
    end
    // Equivalent inverse cipher key
    return ref_shift(ref_mix(s, 1'b1), 1'b1) ^ (key_inv ? ref_mix(k, 1'b1) : k);
  endfunction

  function automatic logic [ADDR_W-1:0] reg_addr(input logic [7:0] base, input int w);
    return ADDR_W'(base) + ADDR_W'(4 * w);
  endfunction

  task automatic check_state(input string name, input aes_state_t exp, input aes_state_t act);
    n_checks++;
    if (exp !== act) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      n_errors++;
      test_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    n_checks++;
    if (exp !== act) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      n_errors++;
      test_errors++;
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (exp !== act) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      n_errors++;
      test_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic apply_reset();
    rst_n_i = 1'b0;
    repeat (10) @(negedge pclk_i);
    rst_n_i = 1'b1;
  endtask

  // Setup then access from a falling edge
  task automatic apb_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    int waited;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge pclk_i);
    penable_i = 1'b1;
    waited    = 0;
    // Sample mid low phase once outputs settle
    #1;
    while (!pready_o && waited < TIMEOUT) begin
      @(negedge pclk_i);
      #1;
      waited++;
    end
    if (!pready_o) begin
      $display("Timeout: pready_o never rose for address %h", addr);
      n_errors++;
      test_errors++;
    end
    rdata = prdata_o;
    err   = pslverr_o;
    @(negedge pclk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
                           output logic err);
    logic [31:0] unused;
    apb_xfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
                          output logic err);
    apb_xfer(1'b0, addr, 32'h0, data, err);
  endtask

  // Load operands, start, then read back the sum
  task automatic run_round(input aes_state_t s, input aes_state_t k, input ciph_op_e op,
                           input logic key_inv, output aes_state_t res);
    logic [31:0] rd;
    logic        err;
    for (int w = 0; w < 4; w++) begin
      apb_write(reg_addr(STATE_BASE, w), s[32*w +: 32], err);
      check_bit("state write error", 1'b0, err);
      apb_write(reg_addr(KEY_BASE, w), k[32*w +: 32], err);
      check_bit("key write error", 1'b0, err);
    end
    apb_write(reg_addr(CTRL_OFFSET, 0), {29'h0, key_inv, op, 1'b1}, err);
    // Very next access phase must see done
    apb_read(reg_addr(STATUS_OFFSET, 0), rd, err);
    check_bit("done after start", 1'b1, rd[0]);
    for (int w = 0; w < 4; w++) begin
      apb_read(reg_addr(RESULT_BASE, w), rd, err);
      res[32*w +: 32] = rd;
    end
  endtask

  initial begin : main
    aes_state_t  s;
    aes_state_t  k;
    aes_state_t  res;
    aes_state_t  prev;
    logic [31:0] rd;
    logic        err;
    pclk_i      = 1'b0;
    rst_n_i     = 1'b0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    lfsr_q      = 32'h7b82_c265;
    n_checks    = 0;
    n_errors    = 0;
    test_errors = 0;
    apply_reset();

    apb_read(reg_addr(STATUS_OFFSET, 0), rd, err);
    check_word("reset status", 32'h0, rd);
    check_bit("reset status pslverr", 1'b0, err);
    apb_read(reg_addr(CTRL_OFFSET, 0), rd, err);
    check_word("reset ctrl", 32'h0, rd);
    for (int w = 0; w < 4; w++) begin
      apb_read(reg_addr(RESULT_BASE, w), rd, err);
      check_word("reset result", 32'h0, rd);
    end
    // Setup phase on an unmapped address raises no error
    psel_i  = 1'b1;
    paddr_i = ADDR_W'(UNMAPPED[3]);
    #1;
    check_bit("reset setup pslverr", 1'b0, pslverr_o);
    @(negedge pclk_i);
    psel_i = 1'b0;
    finish_test("reset");

    // FIPS-197 column db 13 53 45 in every column
    run_round({4{32'h4553_13db}}, '0, CIPH_FWD, 1'b0, res);
    check_state("fips column", {4{32'hbca1_4d8e}}, res);
    for (int i = 0; i < 20; i++) begin
      s = rand_state();
      k = rand_state();
      run_round(s, k, CIPH_FWD, 1'b0, res);
      check_state("forward round", ref_round(s, k, CIPH_FWD, 1'b0), res);
    end
    finish_test("forward round");

    for (int i = 0; i < 20; i++) begin
      s = rand_state();
      k = rand_state();
      run_round(s, k, CIPH_INV, 1'b0, res);
      check_state("inverse round", ref_round(s, k, CIPH_INV, 1'b0), res);
    end
    // Forward then inverse with zero key
    s = rand_state();
    run_round(s, '0, CIPH_FWD, 1'b0, prev);
    run_round(prev, '0, CIPH_INV, 1'b0, res);
    check_state("round trip", s, res);
    finish_test("inverse round");

    for (int i = 0; i < 10; i++) begin
      s = rand_state();
      k = rand_state();
      run_round(s, k, CIPH_INV, 1'b1, res);
      check_state("equivalent inverse", ref_round(s, k, CIPH_INV, 1'b1), res);
    end
    // key_inv ignored going forward
    for (int i = 0; i < 5; i++) begin
      s = rand_state();
      k = rand_state();
      run_round(s, k, CIPH_FWD, 1'b1, res);
      check_state("forward key_inv", ref_round(s, k, CIPH_FWD, 1'b0), res);
    end
    finish_test("equivalent inverse key");

    s = rand_state();
    k = rand_state();
    for (int w = 0; w < 4; w++) begin
      apb_write(reg_addr(STATE_BASE, w), s[32*w +: 32], err);
      apb_write(reg_addr(KEY_BASE, w), k[32*w +: 32], err);
    end
    for (int w = 0; w < 4; w++) begin
      apb_read(reg_addr(STATE_BASE, w), rd, err);
      check_word("state readback", s[32*w +: 32], rd);
      apb_read(reg_addr(KEY_BASE, w), rd, err);
      check_word("key readback", k[32*w +: 32], rd);
    end
    apb_write(reg_addr(CTRL_OFFSET, 0), 32'h7, err);
    apb_read(reg_addr(CTRL_OFFSET, 0), rd, err);
    check_word("ctrl readback", 32'h6, rd);
    for (int w = 0; w < 4; w++) begin
      apb_read(reg_addr(RESULT_BASE, w), rd, err);
      prev[32*w +: 32] = rd;
    end
    for (int i = 0; i < 5; i++) begin
      apb_read(ADDR_W'(UNMAPPED[i]), rd, err);
      check_bit("unmapped read pslverr", 1'b1, err);
    end
    apb_write(reg_addr(STATUS_OFFSET, 0), 32'hffff_ffff, err);
    check_bit("status write pslverr", 1'b1, err);
    apb_write(reg_addr(RESULT_BASE, 0), 32'h1234_5678, err);
    check_bit("result write pslverr", 1'b1, err);
    apb_write(reg_addr(RESULT_BASE, 3), 32'h9abc_def0, err);
    check_bit("result write pslverr", 1'b1, err);
    for (int w = 0; w < 4; w++) begin
      apb_read(reg_addr(RESULT_BASE, w), rd, err);
      res[32*w +: 32] = rd;
    end
    check_state("result after bad access", prev, res);
    // Fresh reset so done starts low again
    apply_reset();
    apb_read(reg_addr(STATUS_OFFSET, 0), rd, err);
    check_word("status before start", 32'h0, rd);
    apb_write(reg_addr(CTRL_OFFSET, 0), 32'h1, err);
    apb_read(reg_addr(STATUS_OFFSET, 0), rd, err);
    check_word("status after start", 32'h1, rd);
    finish_test("register access");

    $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
logic/aes_mix_pkg.sv
logic/aes_cfg_if.sv
logic/aes_mix_single_column.sv
logic/aes_state_mix.sv
logic/aes_round_key_prep.sv
logic/aes_round_combine.sv
logic/aes_apb_regs.sv
logic/aes_mix_apb.sv
verif/aes_mix_apb_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sources.f --top-module aes_mix_apb_tb \
  && ./obj_dir/Vaes_mix_apb_tb | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
